//--- verilog.f
+incdir+design
design/arbiter_pkg.sv
design/sync_fifo.sv
design/burst_arbiter.sv
design/mig_write_issuer.sv
design/flush_tracker.sv
design/memory_arbiter.sv
test/memory_arbiter_chk.sv
test/memory_arbiter_tb.sv

//--- Makefile
# Verilator build and run for the memory arbiter testbench

VERILATOR ?= verilator
TOP ?= memory_arbiter_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "Simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/memory_arbiter_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "arbiter_params.svh"

module memory_arbiter_tb;

	localparam int BEATS = `ARB_BEATS_PER_BURST;
	localparam int TIMEOUT_CYCLES = 5000;

	logic clk_ram;
	logic trig_rst_arbiter_2x;
	arbiter_pkg::client_port_t la0_port;
	arbiter_pkg::client_port_t la1_port;
	logic app_rdy;
	logic app_wdf_rdy;
	logic flush_arbiter;
	logic la0_flush_complete;
	logic la1_flush_complete;
	arbiter_pkg::client_rd_t la0_rd;
	arbiter_pkg::client_rd_t la1_rd;
	arbiter_pkg::mig_cmd_t mig_cmd;
	arbiter_pkg::mig_wdf_t mig_wdf;
	logic flushing;
	logic flush_done;

	// Pod models
	arbiter_pkg::client_port_t pod_port [2];
	arbiter_pkg::beat_t pod_beats [2][$];
	arbiter_pkg::addr_t pod_addrs [2][$];
	arbiter_pkg::beat_t beat_stage [2];
	arbiter_pkg::addr_t addr_stage [2];
	logic [1:0] data_strobe_seen;
	logic [1:0] addr_strobe_seen;
	int strobe_count [2];

	// Bursts per port before arbitration order is applied
	arbiter_pkg::addr_t pend_addrs [2][$];
	arbiter_pkg::beat_t pend_beats [2][$];

	// Expected and accepted controller traffic
	arbiter_pkg::addr_t exp_addrs [$];
	arbiter_pkg::word_t exp_words [$];
	logic exp_ends [$];
	arbiter_pkg::addr_t acc_addrs [$];
	logic [2:0] acc_cmds [$];
	arbiter_pkg::word_t acc_words [$];
	logic acc_ends [$];

	logic [31:0] data_seed;
	logic [31:0] stall_seed;
	logic stall_enable;
	logic flush_window;
	int flush_done_count;
	int mismatch_count;
	int failure_count;

	//////////////////////////////////////////////////
	// DUT

	memory_arbiter UUT (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.la0_port(la0_port),
		.la1_port(la1_port),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.flush_arbiter(flush_arbiter),
		.la0_flush_complete(la0_flush_complete),
		.la1_flush_complete(la1_flush_complete),
		.la0_rd(la0_rd),
		.la1_rd(la1_rd),
		.mig_cmd(mig_cmd),
		.mig_wdf(mig_wdf),
		.flushing(flushing),
		.flush_done(flush_done)
	);

	bind memory_arbiter memory_arbiter_chk u_chk (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.mig_cmd(mig_cmd),
		.mig_wdf(mig_wdf),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.flushing(flushing),
		.flush_done(flush_done)
	);

	assign la0_port = pod_port[0];
	assign la1_port = pod_port[1];

	// 8 ns period
	always #4 clk_ram = ~clk_ram;

	//////////////////////////////////////////////////
	// Random numbers

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		lcg_step = state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [31:0] next_data();
		data_seed = lcg_step(data_seed);
		next_data = data_seed;
	endfunction

	//////////////////////////////////////////////////
	// Pod and controller models

	// Entry appears two cycles after its strobe and size drops one cycle after
	always @(posedge clk_ram) begin : pod_model
		arbiter_pkg::client_rd_t cur_rd;
		#1;
		for (int p = 0; p < 2; p++) begin
			cur_rd = (p == 0) ? la0_rd : la1_rd;
			pod_port[p].data = beat_stage[p];
			pod_port[p].addr = addr_stage[p];
			// Pop for the strobe of the previous cycle
			if (data_strobe_seen[p] && (pod_beats[p].size() != 0)) begin
				beat_stage[p] = pod_beats[p].pop_front();
			end
			if (addr_strobe_seen[p] && (pod_addrs[p].size() != 0)) begin
				addr_stage[p] = pod_addrs[p].pop_front();
			end
			pod_port[p].data_size = arbiter_pkg::dsize_t'(pod_beats[p].size());
			pod_port[p].addr_size = arbiter_pkg::asize_t'(pod_addrs[p].size());
			data_strobe_seen[p] = cur_rd.data_rd;
			addr_strobe_seen[p] = cur_rd.addr_rd;
			if (cur_rd.data_rd || cur_rd.addr_rd) begin
				strobe_count[p]++;
			end
		end
	end

	// Random ready drops in roughly one cycle out of four each
	always @(posedge clk_ram) begin : controller_model
		#1;
		if (stall_enable) begin
			stall_seed = lcg_step(stall_seed);
			app_rdy = (stall_seed[17:16] != 2'b00);
			app_wdf_rdy = (stall_seed[25:24] != 2'b00);
		end
	end

	// Acceptance log and flush monitor at mid cycle
	always @(negedge clk_ram) begin
		if (!trig_rst_arbiter_2x) begin
			if (mig_cmd.en && app_rdy) begin
				acc_addrs.push_back(mig_cmd.addr);
				acc_cmds.push_back(mig_cmd.cmd);
			end
			if (mig_wdf.wren && app_wdf_rdy) begin
				acc_words.push_back(mig_wdf.data);
				acc_ends.push_back(mig_wdf.data_end);
			end
			if (flush_done) begin
				flush_done_count++;
				flush_window = 1'b0;
				if ((la0_port.data_size != 0) || (la1_port.data_size != 0)) begin
					report_failure("flush_done while a pod queue still holds data");
				end
				if ((acc_addrs.size() < exp_addrs.size())
						|| (acc_words.size() < exp_words.size())) begin
					report_failure("flush_done before all expected traffic was accepted");
				end
			end else if (flush_window && !flushing) begin
				report_failure("flushing dropped before flush_done");
				flush_window = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		mismatch_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		failure_count++;
	endtask

	task automatic check_low(input logic value, input string name);
		if (value !== 1'b0) begin
			report_mismatch($sformatf("%s is %b after reset, expected 0", name, value));
		end
	endtask

	// Five cycles of reset with all queues and logs cleared
	task automatic reset_dut();
		@(posedge clk_ram);
		#1;
		trig_rst_arbiter_2x = 1'b1;
		app_rdy = 1'b1;
		app_wdf_rdy = 1'b1;
		stall_enable = 1'b0;
		flush_arbiter = 1'b0;
		la0_flush_complete = 1'b0;
		la1_flush_complete = 1'b0;
		for (int p = 0; p < 2; p++) begin
			pod_beats[p].delete();
			pod_addrs[p].delete();
			pend_addrs[p].delete();
			pend_beats[p].delete();
			strobe_count[p] = 0;
		end
		exp_addrs.delete();
		exp_words.delete();
		exp_ends.delete();
		acc_addrs.delete();
		acc_cmds.delete();
		acc_words.delete();
		acc_ends.delete();
		flush_window = 1'b0;
		flush_done_count = 0;
		repeat (5) @(posedge clk_ram);
		#1;
		trig_rst_arbiter_2x = 1'b0;
	endtask

	// One address and four beats per burst
	// Top address bit marks the port
	task automatic push_burst(input int p);
		arbiter_pkg::addr_t addr;
		arbiter_pkg::beat_t beat;
		logic [31:0] r;
		r = next_data();
		addr = {p[0], r[27:0]};
		pod_addrs[p].push_back(addr);
		pend_addrs[p].push_back(addr);
		for (int i = 0; i < BEATS; i++) begin
			beat = {next_data(), next_data(), next_data(), next_data()};
			pod_beats[p].push_back(beat);
			pend_beats[p].push_back(beat);
		end
	endtask

	// Pointer starts at port 0 and advances on every burst
	task automatic merge_expected();
		int rr;
		int pick;
		arbiter_pkg::beat_t b [BEATS];
		rr = 0;
		while ((pend_addrs[0].size() + pend_addrs[1].size()) != 0) begin
			pick = (pend_addrs[rr].size() != 0) ? rr : 1 - rr;
			exp_addrs.push_back(pend_addrs[pick].pop_front());
			for (int i = 0; i < BEATS; i++) begin
				b[i] = pend_beats[pick].pop_front();
			end
			// Earlier beat in the upper half and end marker on the last word
			for (int i = 0; i < BEATS; i += 2) begin
				exp_words.push_back({b[i], b[i+1]});
				exp_ends.push_back(i + 2 == BEATS);
			end
			rr = 1 - rr;
		end
	endtask

	task automatic wait_for_traffic(input string name);
		int cycles;
		cycles = 0;
		while (((acc_words.size() < exp_words.size()) || (acc_addrs.size() < exp_addrs.size()))
				&& (cycles < TIMEOUT_CYCLES)) begin
			@(posedge clk_ram);
			cycles++;
		end
		if ((acc_words.size() < exp_words.size()) || (acc_addrs.size() < exp_addrs.size())) begin
			report_failure($sformatf("%s timed out waiting for controller traffic", name));
		end
		// Idle time to catch extra traffic
		repeat (20) @(posedge clk_ram);
		#1;
	endtask

	task automatic compare_traffic(input string name);
		if (acc_addrs.size() != exp_addrs.size()) begin
			report_mismatch($sformatf("%s got %0d commands, expected %0d",
				name, acc_addrs.size(), exp_addrs.size()));
		end
		if (acc_words.size() != exp_words.size()) begin
			report_mismatch($sformatf("%s got %0d words, expected %0d",
				name, acc_words.size(), exp_words.size()));
		end
		for (int i = 0; (i < acc_addrs.size()) && (i < exp_addrs.size()); i++) begin
			if ((acc_addrs[i] != exp_addrs[i]) || (acc_cmds[i] != 3'd0)) begin
				report_mismatch($sformatf("%s command %0d is cmd %0d address %h, expected 0 %h",
					name, i, acc_cmds[i], acc_addrs[i], exp_addrs[i]));
			end
		end
		for (int i = 0; (i < acc_words.size()) && (i < exp_words.size()); i++) begin
			if ((acc_words[i] != exp_words[i]) || (acc_ends[i] != exp_ends[i])) begin
				report_mismatch($sformatf("%s word %0d is %h end %b, expected %h end %b",
					name, i, acc_words[i], acc_ends[i], exp_words[i], exp_ends[i]));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset();
		reset_dut();
		check_low(la0_rd.data_rd, "la0 data strobe");
		check_low(la0_rd.addr_rd, "la0 address strobe");
		check_low(la1_rd.data_rd, "la1 data strobe");
		check_low(la1_rd.addr_rd, "la1 address strobe");
		check_low(UUT.cmd_wr_en, "command FIFO write enable");
		check_low(UUT.data_wr_en, "data FIFO write enable");
		check_low(UUT.cmd_rd_en, "command FIFO read enable");
		check_low(UUT.data_rd_en, "data FIFO read enable");
		check_low(mig_cmd.en, "mig_cmd enable");
		check_low(mig_wdf.wren, "mig_wdf write enable");
		check_low(mig_wdf.data_end, "mig_wdf end marker");
		check_low(flushing, "flushing");
		check_low(flush_done, "flush_done");
		check_low(UUT.u_burst_arbiter.rr, "round-robin pointer");
		if ((UUT.cmd_empty !== 1'b1) || (UUT.data_empty !== 1'b1)) begin
			report_mismatch("FIFOs not empty after reset");
		end
	endtask

	task automatic test_single_burst();
		reset_dut();
		push_burst(0);
		merge_expected();
		wait_for_traffic("single burst");
		compare_traffic("single burst");
	endtask

	task automatic test_round_robin();
		reset_dut();
		for (int i = 0; i < 4; i++) begin
			push_burst(0);
			push_burst(1);
		end
		merge_expected();
		wait_for_traffic("round robin");
		compare_traffic("round robin");
		// Port 0 first and alternating after that
		for (int i = 0; i < acc_addrs.size(); i++) begin
			if (acc_addrs[i][`ARB_ADDR_W-1] != i[0]) begin
				report_mismatch($sformatf("round robin command %0d came from the wrong port", i));
			end
		end
	endtask

	task automatic test_fall_through();
		reset_dut();
		for (int i = 0; i < 4; i++) begin
			push_burst(1);
		end
		merge_expected();
		wait_for_traffic("fall through");
		compare_traffic("fall through");
		if (strobe_count[0] != 0) begin
			report_failure("port 0 was strobed while it held no data");
		end
	endtask

	task automatic test_back_pressure();
		reset_dut();
		stall_enable = 1'b1;
		for (int i = 0; i < 10; i++) begin
			push_burst(int'(next_data() >> 31));
		end
		merge_expected();
		wait_for_traffic("back pressure");
		stall_enable = 1'b0;
		app_rdy = 1'b1;
		app_wdf_rdy = 1'b1;
		compare_traffic("back pressure");
	endtask

	task automatic test_flush();
		int cycles;
		reset_dut();
		for (int i = 0; i < 3; i++) begin
			push_burst(0);
			push_burst(1);
		end
		merge_expected();
		@(posedge clk_ram);
		#1;
		flush_arbiter = 1'b1;
		@(posedge clk_ram);
		#1;
		flush_arbiter = 1'b0;
		if (!flushing) begin
			report_failure("flushing did not rise after the flush request");
		end
		flush_window = 1'b1;
		// Pods finish later
		repeat (12) @(posedge clk_ram);
		#1;
		la0_flush_complete = 1'b1;
		la1_flush_complete = 1'b1;
		cycles = 0;
		while ((flush_done_count == 0) && (cycles < TIMEOUT_CYCLES)) begin
			@(posedge clk_ram);
			cycles++;
		end
		if (flush_done_count == 0) begin
			report_failure("flush timed out waiting for flush_done");
		end
		wait_for_traffic("flush");
		if (flush_done_count != 1) begin
			report_mismatch($sformatf("flush_done pulsed %0d times, expected 1", flush_done_count));
		end
		compare_traffic("flush");
		la0_flush_complete = 1'b0;
		la1_flush_complete = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Sequence and verdict

	initial begin
		clk_ram = 1'b0;
		trig_rst_arbiter_2x = 1'b1;
		app_rdy = 1'b1;
		app_wdf_rdy = 1'b1;
		flush_arbiter = 1'b0;
		la0_flush_complete = 1'b0;
		la1_flush_complete = 1'b0;
		for (int p = 0; p < 2; p++) begin
			pod_port[p] = '0;
			beat_stage[p] = '0;
			addr_stage[p] = '0;
			strobe_count[p] = 0;
		end
		data_strobe_seen = '0;
		addr_strobe_seen = '0;
		data_seed = 32'd67735;
		stall_seed = 32'd67735;
		stall_enable = 1'b0;
		flush_window = 1'b0;
		flush_done_count = 0;
		mismatch_count = 0;
		failure_count = 0;

		test_reset();
		test_single_burst();
		test_round_robin();
		test_fall_through();
		test_back_pressure();
		test_flush();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if ((mismatch_count == 0) && (failure_count == 0)) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/memory_arbiter_chk.sv
`timescale 1ns/1ns
`default_nettype none

module memory_arbiter_chk (
	input wire clk_ram,
	input wire trig_rst_arbiter_2x,
	input wire arbiter_pkg::mig_cmd_t mig_cmd,
	input wire arbiter_pkg::mig_wdf_t mig_wdf,
	input wire app_rdy,
	input wire app_wdf_rdy,
	input wire flushing,
	input wire flush_done
);

	//////////////////////////////////////////////////
	// Controller write interface

	// Stalled command holds every field
	cmd_held: assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		(mig_cmd.en && !app_rdy) |=> (mig_cmd == $past(mig_cmd)))
		else $error("mig_cmd changed while app_rdy was low");

	// Stalled write word holds data and end marker
	wdf_held: assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		(mig_wdf.wren && !app_wdf_rdy) |=> (mig_wdf == $past(mig_wdf)))
		else $error("mig_wdf changed while app_wdf_rdy was low");

	//////////////////////////////////////////////////
	// Flush tracker

	done_pulse: assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		flush_done |=> !flush_done)
		else $error("flush_done lasted more than one cycle");

	done_not_flushing: assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		flush_done |-> !flushing)
		else $error("flushing high together with flush_done");

endmodule

`default_nettype wire

//--- design/memory_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "arbiter_params.svh"

module memory_arbiter (
	input wire clk_ram,
	input wire trig_rst_arbiter_2x,
	input wire arbiter_pkg::client_port_t la0_port,
	input wire arbiter_pkg::client_port_t la1_port,
	input wire app_rdy,
	input wire app_wdf_rdy,
	input wire flush_arbiter,
	input wire la0_flush_complete,
	input wire la1_flush_complete,
	output arbiter_pkg::client_rd_t la0_rd,
	output arbiter_pkg::client_rd_t la1_rd,
	output arbiter_pkg::mig_cmd_t mig_cmd,
	output arbiter_pkg::mig_wdf_t mig_wdf,
	output logic flushing,
	output logic flush_done
);

	arbiter_pkg::client_port_t ports [`ARB_NUM_PORTS];
	arbiter_pkg::client_rd_t rd [`ARB_NUM_PORTS];

	logic cmd_wr_en;
	arbiter_pkg::cmd_entry_t cmd_wr_data;
	logic data_wr_en;
	arbiter_pkg::word_t data_wr_data;
	logic busy;

	arbiter_pkg::cmd_cnt_t cmd_free;
	arbiter_pkg::data_cnt_t data_free;
	arbiter_pkg::data_cnt_t data_count;
	logic cmd_rd_en;
	logic data_rd_en;
	arbiter_pkg::cmd_entry_t cmd_rd_data;
	arbiter_pkg::word_t data_rd_data;
	logic cmd_empty;
	logic data_empty;
	logic pending;
	logic drained;

	//////////////////////////////////////////////////
	// Pod ports as arrays

	assign ports[0] = la0_port;
	assign ports[1] = la1_port;
	assign la0_rd = rd[0];
	assign la1_rd = rd[1];

	//////////////////////////////////////////////////
	// Input side

	burst_arbiter u_burst_arbiter (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.ports(ports),
		.data_free(data_free),
		.cmd_free(cmd_free),
		.rd(rd),
		.cmd_wr_en(cmd_wr_en),
		.cmd_wr_data(cmd_wr_data),
		.data_wr_en(data_wr_en),
		.data_wr_data(data_wr_data),
		.busy(busy)
	);

	//////////////////////////////////////////////////
	// Command and data buffering

	sync_fifo #(
		.WIDTH($bits(arbiter_pkg::cmd_entry_t)),
		.DEPTH(`ARB_CMD_FIFO_DEPTH)
	) cmd_fifo (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.wr_en(cmd_wr_en),
		.wr_data(cmd_wr_data),
		.rd_en(cmd_rd_en),
		.free(cmd_free),
		.rd_data(cmd_rd_data),
		.count(),
		.empty(cmd_empty)
	);

	sync_fifo #(
		.WIDTH(`ARB_WORD_W),
		.DEPTH(`ARB_DATA_FIFO_DEPTH)
	) data_fifo (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.wr_en(data_wr_en),
		.wr_data(data_wr_data),
		.rd_en(data_rd_en),
		.free(data_free),
		.rd_data(data_rd_data),
		.count(data_count),
		.empty(data_empty)
	);

	//////////////////////////////////////////////////
	// Output side

	mig_write_issuer u_mig_write_issuer (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.cmd_rd_data(cmd_rd_data),
		.cmd_empty(cmd_empty),
		.data_rd_data(data_rd_data),
		.data_count(data_count),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.cmd_rd_en(cmd_rd_en),
		.data_rd_en(data_rd_en),
		.mig_cmd(mig_cmd),
		.mig_wdf(mig_wdf),
		.pending(pending)
	);

	// Nothing left anywhere past the arbiter
	assign drained = cmd_empty && data_empty && !pending;

	flush_tracker u_flush_tracker (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.flush_arbiter(flush_arbiter),
		.la0_flush_complete(la0_flush_complete),
		.la1_flush_complete(la1_flush_complete),
		.la0_data_size(la0_port.data_size),
		.la1_data_size(la1_port.data_size),
		.fifos_empty(drained),
		.arbiter_busy(busy),
		.flushing(flushing),
		.flush_done(flush_done)
	);

endmodule

`default_nettype wire

//--- design/flush_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module flush_tracker (
	input wire clk_ram,
	input wire trig_rst_arbiter_2x,
	input wire flush_arbiter,
	input wire la0_flush_complete,
	input wire la1_flush_complete,
	input wire arbiter_pkg::dsize_t la0_data_size,
	input wire arbiter_pkg::dsize_t la1_data_size,
	input wire fifos_empty,
	input wire arbiter_busy,
	output logic flushing,
	output logic flush_done
);

	arbiter_pkg::flush_state_t state;

	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			state <= arbiter_pkg::IDLE;
			flushing <= 1'b0;
			flush_done <= 1'b0;
		end else begin
			flush_done <= 1'b0;

			case (state)
				// Wait for a request
				arbiter_pkg::IDLE: begin
					if (flush_arbiter) begin
						state <= arbiter_pkg::POD_WAIT;
						flushing <= 1'b1;
					end
				end

				// Both pods push their channel buffers into the pod queues
				arbiter_pkg::POD_WAIT: begin
					if (la0_flush_complete && la1_flush_complete) begin
						state <= arbiter_pkg::POD_WAIT2;
					end
				end

				// Pod queues drained by the arbiter
				arbiter_pkg::POD_WAIT2: begin
					if ((la0_data_size == '0) && (la1_data_size == '0)) begin
						state <= arbiter_pkg::ARBITER_WAIT;
					end
				end

				// Last burst out of both FIFOs and the issuer
				arbiter_pkg::ARBITER_WAIT: begin
					if (fifos_empty && !arbiter_busy) begin
						state <= arbiter_pkg::DONE;
						flushing <= 1'b0;
						flush_done <= 1'b1;
					end
				end

				// Sticky until reset
				arbiter_pkg::DONE: begin
					state <= arbiter_pkg::DONE;
				end

				default: begin
					state <= arbiter_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/mig_write_issuer.sv
`timescale 1ns/1ns
`default_nettype none

module mig_write_issuer (
	input wire clk_ram,
	input wire trig_rst_arbiter_2x,
	input wire arbiter_pkg::cmd_entry_t cmd_rd_data,
	input wire cmd_empty,
	input wire arbiter_pkg::word_t data_rd_data,
	input wire arbiter_pkg::data_cnt_t data_count,
	input wire app_rdy,
	input wire app_wdf_rdy,
	output logic cmd_rd_en,
	output logic data_rd_en,
	output arbiter_pkg::mig_cmd_t mig_cmd,
	output arbiter_pkg::mig_wdf_t mig_wdf,
	output logic pending
);

	logic pop;
	logic load;
	logic phase;
	logic wdf_accept;

	//////////////////////////////////////////////////
	// FIFO pops

	// One command plus both of its words must be on hand
	assign pop = !cmd_empty && (data_count >= 2) && app_rdy && app_wdf_rdy && !pending;
	assign cmd_rd_en = pop;
	// Second word is fetched right after the first
	// and waits in the FIFO read register
	assign data_rd_en = pop || load;

	// Busy from the read-data cycle until both outputs are delivered
	assign pending = load || mig_cmd.en || mig_wdf.wren;

	assign wdf_accept = mig_wdf.wren && app_wdf_rdy;

	//////////////////////////////////////////////////
	// Controller outputs

	always_ff @(posedge clk_ram) begin
		// Payload moves only on load or on acceptance of the first word
		if (load) begin
			mig_cmd.addr <= cmd_rd_data.addr;
			mig_cmd.cmd <= {2'b00, cmd_rd_data.cmd};
			mig_wdf.data <= data_rd_data;
		end else if (wdf_accept && !phase) begin
			mig_wdf.data <= data_rd_data;
		end

		if (trig_rst_arbiter_2x) begin
			load <= 1'b0;
			phase <= 1'b0;
			mig_cmd.en <= 1'b0;
			mig_wdf.wren <= 1'b0;
			mig_wdf.data_end <= 1'b0;
		end else begin
			// FIFO read data is valid one cycle after the pop
			load <= pop;

			// Command drops once the controller takes it
			if (mig_cmd.en && app_rdy) begin
				mig_cmd.en <= 1'b0;
			end

			// First accepted word swaps in the second with end set
			// second accepted word closes the burst
			if (wdf_accept) begin
				phase <= !phase;
				mig_wdf.data_end <= !phase;
				mig_wdf.wren <= !phase;
			end

			if (load) begin
				mig_cmd.en <= 1'b1;
				mig_wdf.wren <= 1'b1;
				mig_wdf.data_end <= 1'b0;
				phase <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/burst_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "arbiter_params.svh"

module burst_arbiter (
	input wire clk_ram,
	input wire trig_rst_arbiter_2x,
	input wire arbiter_pkg::client_port_t ports [`ARB_NUM_PORTS],
	input wire arbiter_pkg::data_cnt_t data_free,
	input wire arbiter_pkg::cmd_cnt_t cmd_free,
	output arbiter_pkg::client_rd_t rd [`ARB_NUM_PORTS],
	output logic cmd_wr_en,
	output arbiter_pkg::cmd_entry_t cmd_wr_data,
	output logic data_wr_en,
	output arbiter_pkg::word_t data_wr_data,
	output logic busy
);

	localparam int NP = `ARB_NUM_PORTS;
	localparam int BEATS = `ARB_BEATS_PER_BURST;
	// Last word lands three cycles after the last strobe
	localparam int LAST_POS = BEATS + 3;

	logic [NP-1:0] ready;
	logic hit;
	arbiter_pkg::port_idx_t sel;
	arbiter_pkg::port_idx_t rr;
	arbiter_pkg::port_idx_t cur;
	logic room;
	logic start;
	logic [$clog2(LAST_POS+1)-1:0] pos;
	logic addr_v1;
	logic addr_v2;
	logic data_v1;
	logic data_v2;
	logic phase;

	//////////////////////////////////////////////////
	// Port selection

	// A port needs a full burst of beats plus one address
	always_comb begin
		for (int i = 0; i < NP; i++) begin
			ready[i] = (ports[i].data_size >= BEATS) && (ports[i].addr_size != '0);
		end
	end

	// Round robin pick first
	// Otherwise fall through to the lowest ready port
	always_comb begin
		hit = ready[rr];
		sel = rr;
		if (!hit) begin
			for (int i = 0; i < NP; i++) begin
				if (!hit && ready[i]) begin
					hit = 1'b1;
					sel = arbiter_pkg::port_idx_t'(i);
				end
			end
		end
	end

	// Output FIFOs must fit a whole burst
	assign room = (data_free >= `ARB_DATA_FREE_MIN) && (cmd_free >= `ARB_CMD_FREE_MIN);
	// New bursts only from idle
	assign start = (pos == '0) && hit && room;
	// Busy from the start cycle until the last word is pushed
	assign busy = (pos != '0) || start;

	//////////////////////////////////////////////////
	// Strobes and burst position

	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			for (int i = 0; i < NP; i++) begin
				rd[i] <= '0;
			end
			pos <= '0;
			rr <= '0;
			cur <= '0;
		end else begin
			// Strobes are single cycle by default
			for (int i = 0; i < NP; i++) begin
				rd[i] <= '0;
			end

			if (start) begin
				rd[sel].addr_rd <= 1'b1;
				rd[sel].data_rd <= 1'b1;
				cur <= sel;
				pos <= 1'b1;
				rr <= (rr == NP - 1) ? '0 : rr + 1'b1;
			end else if (pos != '0) begin
				// Remaining data strobes back to back
				if (pos < BEATS) begin
					rd[cur].data_rd <= 1'b1;
				end
				pos <= (pos == LAST_POS) ? '0 : pos + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Return path

	// Pods answer two cycles after each strobe
	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			addr_v1 <= 1'b0;
			addr_v2 <= 1'b0;
			data_v1 <= 1'b0;
			data_v2 <= 1'b0;
		end else begin
			addr_v1 <= (pos == 1);
			addr_v2 <= addr_v1;
			data_v1 <= (pos >= 1) && (pos <= BEATS);
			data_v2 <= data_v1;
		end
	end

	// Address goes straight into the command FIFO as a write
	assign cmd_wr_en = addr_v2;
	assign cmd_wr_data = '{cmd: 1'b0, addr: ports[cur].addr};

	// Beat pairs shift in from the bottom
	// so the earlier beat ends up in the upper half
	always_ff @(posedge clk_ram) begin
		if (data_v2) begin
			data_wr_data <= {data_wr_data[`ARB_BEAT_W-1:0], ports[cur].data};
		end

		if (trig_rst_arbiter_2x) begin
			phase <= 1'b0;
			data_wr_en <= 1'b0;
		end else begin
			data_wr_en <= 1'b0;
			if (data_v2) begin
				phase <= !phase;
				// Second beat of a pair completes a word
				if (phase) begin
					data_wr_en <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input wire clk_ram,
	input wire trig_rst_arbiter_2x,
	input wire wr_en,
	input wire [WIDTH-1:0] wr_data,
	input wire rd_en,
	output logic [$clog2(DEPTH+1)-1:0] free,
	output logic [WIDTH-1:0] rd_data,
	output logic [$clog2(DEPTH+1)-1:0] count,
	output logic empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	// Writes to a full FIFO and reads from an empty one are ignored
	assign do_wr = wr_en && (count != DEPTH);
	assign do_rd = rd_en && (count != 0);

	// Storage with registered read port
	always_ff @(posedge clk_ram) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
		if (do_rd) begin
			rd_data <= mem[rd_ptr];
		end
	end

	// Pointers wrap explicitly for any depth
	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Writer side view
	assign free = CW'(DEPTH) - count;
	// Reader side view
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- design/arbiter_pkg.sv
`default_nettype none

`include "arbiter_params.svh"

package arbiter_pkg;

	//////////////////////////////////////////////////
	// Plain vector widths

	typedef logic [`ARB_BEAT_W-1:0] beat_t;
	typedef logic [`ARB_WORD_W-1:0] word_t;
	typedef logic [`ARB_ADDR_W-1:0] addr_t;
	typedef logic [`ARB_DSIZE_W-1:0] dsize_t;
	typedef logic [`ARB_ASIZE_W-1:0] asize_t;
	typedef logic [$clog2(`ARB_NUM_PORTS)-1:0] port_idx_t;
	// Fill and free counts of the two internal FIFOs
	typedef logic [$clog2(`ARB_DATA_FIFO_DEPTH+1)-1:0] data_cnt_t;
	typedef logic [$clog2(`ARB_CMD_FIFO_DEPTH+1)-1:0] cmd_cnt_t;

	//////////////////////////////////////////////////
	// Bundles

	// Per-pod queue outputs
	typedef struct packed {
		beat_t data;
		addr_t addr;
		dsize_t data_size;
		asize_t addr_size;
	} client_port_t;

	// Per-pod read strobes
	typedef struct packed {
		logic data_rd;
		logic addr_rd;
	} client_rd_t;

	// Command FIFO entry where cmd 0 is a write
	typedef struct packed {
		logic cmd;
		addr_t addr;
	} cmd_entry_t;

	typedef struct packed {
		addr_t addr;
		logic [2:0] cmd;
		logic en;
	} mig_cmd_t;

	typedef struct packed {
		word_t data;
		logic data_end;
		logic wren;
	} mig_wdf_t;

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		POD_WAIT = 3'd1,
		POD_WAIT2 = 3'd2,
		ARBITER_WAIT = 3'd3,
		DONE = 3'd4
	} flush_state_t;

endpackage

`default_nettype wire

//--- design/arbiter_params.svh
`ifndef ARBITER_PARAMS_SVH
`define ARBITER_PARAMS_SVH

//////////////////////////////////////////////////
// Capture port geometry

`define ARB_NUM_PORTS 2
`define ARB_BEAT_W 128
`define ARB_WORD_W 256
`define ARB_ADDR_W 29
`define ARB_DSIZE_W 10
`define ARB_ASIZE_W 8

//////////////////////////////////////////////////
// Burst shape and FIFO sizing

`define ARB_BEATS_PER_BURST 4
`define ARB_DATA_FIFO_DEPTH 512
// One command per two words
`define ARB_CMD_FIFO_DEPTH (`ARB_DATA_FIFO_DEPTH / 2)
`define ARB_DATA_FREE_MIN 5
`define ARB_CMD_FREE_MIN 2

`endif
